// ==== logic/i2c_pkg.sv ====
`default_nettype none

package i2c_pkg;

	localparam int unsigned BURST_BYTES = 11;
	localparam logic [7:0] SENSOR_REG_FIRST = 8'h06; // TEMP2, start of temp/x/y/z block

	typedef enum logic {
		BURST_1  = 1'b0,
		BURST_11 = 1'b1
	} burst_len_e;

	typedef struct packed {
		logic       rd; // 0 = register write
		burst_len_e burst;
		logic [6:0] dev_addr;
		logic [7:0] reg_addr;
		logic [7:0] wdata;
	} i2c_cmd_t;

	// sensor register order, first byte is most significant
	typedef struct packed {
		logic [15:0] temp;
		logic [23:0] x;
		logic [23:0] y;
		logic [23:0] z;
	} sample_f_t;

	typedef union packed {
		logic [0:BURST_BYTES-1][7:0] bytes; // bytes[0] first on the bus
		sample_f_t                   f;
	} sample_u;

	typedef struct packed {
		logic    nack;
		sample_u data;
	} i2c_rsp_t;

	typedef enum logic [1:0] {
		OP_START = 2'd0,
		OP_STOP  = 2'd1,
		OP_WRITE = 2'd2,
		OP_READ  = 2'd3
	} bus_op_e;

	typedef struct packed {
		bus_op_e    op;
		logic [7:0] data;
		logic       last; // NACK the read byte
	} bus_cmd_t;

	typedef struct packed {
		logic [7:0] data;
		logic       nack;
	} bus_rsp_t;

endpackage

`default_nettype wire

// ==== logic/i2c_tick_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_tick_gen #(
	parameter int unsigned QTR_DIV = 16
) (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_en,
	output logic o_tick
);

	localparam int unsigned CW = (QTR_DIV > 1) ? $clog2(QTR_DIV) : 1;

	logic [CW-1:0] cnt;
	logic          wrap;

	assign wrap   = (cnt == CW'(QTR_DIV - 1));
	assign o_tick = i_en & wrap;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			cnt <= '0;
		end else if (!i_en || wrap) begin
			cnt <= '0; // restart so first tick is a full quarter away
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== logic/i2c_bit_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_bit_engine (
	input  logic               i_clk,
	input  logic               i_rst_n,
	input  logic               i_req,
	input  i2c_pkg::bus_cmd_t  i_cmd,
	input  logic               i_tick,
	input  logic               i_sda,
	output logic               o_ack,
	output i2c_pkg::bus_rsp_t  o_rsp,
	output logic               o_tick_en,
	output logic               o_scl_oe,
	output logic               o_sda_oe
);

	import i2c_pkg::*;

	typedef enum logic [1:0] {
		E_IDLE,
		E_RUN,
		E_ACK
	} eng_state_e;

	eng_state_e state;
	bus_op_e    op;
	logic       last;
	logic [7:0] sh;       // tx bits out of [7], rx bits in at [0]
	logic [1:0] ph;       // quarter phase within a bit
	logic [3:0] bit_cnt;  // 8 is the ack slot
	logic       nack;
	logic       ack_bit;
	logic       is_byte;
	logic       op_end;

	assign ack_bit = (bit_cnt == 4'd8);
	assign is_byte = (op == OP_WRITE) || (op == OP_READ);
	assign op_end  = (ph == 2'd3) && (!is_byte || ack_bit);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state    <= E_IDLE;
			ph       <= 2'd0;
			bit_cnt  <= 4'd0;
			nack     <= 1'b0;
			o_scl_oe <= 1'b0;
			o_sda_oe <= 1'b0;
		end else begin
			case (state)
				E_IDLE: begin
					if (i_req) begin
						state   <= E_RUN;
						ph      <= 2'd0;
						bit_cnt <= 4'd0;
						nack    <= 1'b0;
					end
				end
				E_RUN: begin
					if (i_tick) begin
						ph <= ph + 2'd1;
						case (ph)
							2'd0: begin // SCL low, set up SDA
								case (op)
									OP_START: o_sda_oe <= 1'b0;
									OP_STOP:  o_sda_oe <= 1'b1;
									OP_WRITE: o_sda_oe <= ack_bit ? 1'b0 : ~sh[7];
									OP_READ:  o_sda_oe <= ack_bit ? ~last : 1'b0;
								endcase
							end
							2'd1: o_scl_oe <= 1'b0; // SCL rises
							2'd2: begin // SCL high
								case (op)
									OP_START: o_sda_oe <= 1'b1; // start edge
									OP_STOP:  o_sda_oe <= 1'b0; // stop edge
									OP_WRITE: begin
										if (ack_bit) begin
											nack <= i_sda;
										end
									end
									default: ;
								endcase
							end
							2'd3: begin
								if (op != OP_STOP) begin
									o_scl_oe <= 1'b1; // hold SCL low between ops
								end
								bit_cnt <= bit_cnt + 4'd1;
								if (op_end) begin
									state <= E_ACK;
								end
							end
						endcase
					end
				end
				E_ACK: begin
					if (!i_req) begin
						state <= E_IDLE;
					end
				end
				default: state <= E_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (state == E_IDLE && i_req) begin
			op   <= i_cmd.op;
			last <= i_cmd.last;
			sh   <= i_cmd.data;
		end else if (state == E_RUN && i_tick && ph == 2'd2 && is_byte && !ack_bit) begin
			sh <= {sh[6:0], i_sda}; // sample mid SCL high
		end
	end

	assign o_ack     = (state == E_ACK);
	assign o_rsp     = '{data: sh, nack: nack};
	assign o_tick_en = (state == E_RUN);

endmodule

`default_nettype wire

// ==== logic/i2c_seq_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_seq_ctrl #(
	parameter logic [6:0] SENSOR_ADDR = 7'h1D
) (
	input  logic               i_clk,
	input  logic               i_rst_n,
	input  logic               i_req,
	input  i2c_pkg::i2c_cmd_t  i_cmd,
	input  logic               i_hw_mode,
	input  logic               i_drdy,
	input  logic               i_bus_ack,
	input  i2c_pkg::bus_rsp_t  i_bus_rsp,
	output logic               o_ack,
	output logic               o_nack,
	output logic               o_bus_req,
	output i2c_pkg::bus_cmd_t  o_bus_cmd,
	output logic               o_byte_we,
	output logic [3:0]         o_byte_idx,
	output logic               o_done_hw
);

	import i2c_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_ISSUE, // bus_req high, waiting for ack
		S_WAIT,  // bus_req low, waiting for ack to drop
		S_END,
		S_ACK
	} seq_state_e;

	typedef enum logic [2:0] {
		STEP_START,
		STEP_ADDR_W,
		STEP_REG,
		STEP_WDATA,
		STEP_RSTART,
		STEP_ADDR_R,
		STEP_READ,
		STEP_STOP
	} step_e;

	seq_state_e state;
	step_e      step;
	i2c_cmd_t   cmd;
	logic       hw_txn;
	logic [3:0] rd_cnt;
	logic [3:0] last_idx;
	logic [2:0] drdy_sync;
	logic       drdy_rise;
	logic       drdy_pend;
	logic       start_cpu;
	logic       start_hw;

	assign drdy_rise = drdy_sync[1] & ~drdy_sync[2];
	assign start_cpu = (state == S_IDLE) && i_req;
	assign start_hw  = (state == S_IDLE) && !i_req && i_hw_mode && drdy_pend; // cpu wins
	assign last_idx  = (cmd.burst == BURST_11) ? 4'(BURST_BYTES - 1) : 4'd0;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			drdy_sync <= 3'b000;
			drdy_pend <= 1'b0;
		end else begin
			drdy_sync <= {drdy_sync[1:0], i_drdy};
			if (start_hw || !i_hw_mode) begin
				drdy_pend <= 1'b0;
			end else if (drdy_rise) begin
				drdy_pend <= 1'b1; // one edge remembered while busy
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (start_cpu) begin
			cmd <= i_cmd;
		end else if (start_hw) begin
			cmd <= '{rd: 1'b1, burst: BURST_11, dev_addr: SENSOR_ADDR,
				reg_addr: SENSOR_REG_FIRST, wdata: 8'h00};
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state      <= S_IDLE;
			step       <= STEP_START;
			hw_txn     <= 1'b0;
			rd_cnt     <= 4'd0;
			o_nack     <= 1'b0;
			o_bus_req  <= 1'b0;
			o_byte_we  <= 1'b0;
			o_byte_idx <= 4'd0;
			o_done_hw  <= 1'b0;
		end else begin
			o_byte_we <= 1'b0;
			o_done_hw <= 1'b0;
			case (state)
				S_IDLE: begin
					if (start_cpu || start_hw) begin
						hw_txn    <= start_hw;
						step      <= STEP_START;
						rd_cnt    <= 4'd0;
						o_nack    <= 1'b0;
						o_bus_req <= 1'b1;
						state     <= S_ISSUE;
					end
				end
				S_ISSUE: begin
					if (i_bus_ack) begin
						o_bus_req <= 1'b0;
						state     <= (step == STEP_STOP) ? S_END : S_WAIT;
						if (i_bus_rsp.nack) begin
							o_nack <= 1'b1; // only set by writes
						end
						case (step)
							STEP_START:  step <= STEP_ADDR_W;
							STEP_RSTART: step <= STEP_ADDR_R;
							STEP_ADDR_W: step <= i_bus_rsp.nack ? STEP_STOP : STEP_REG;
							STEP_REG: begin
								if (i_bus_rsp.nack) begin
									step <= STEP_STOP;
								end else begin
									step <= cmd.rd ? STEP_RSTART : STEP_WDATA;
								end
							end
							STEP_WDATA:  step <= STEP_STOP;
							STEP_ADDR_R: step <= i_bus_rsp.nack ? STEP_STOP : STEP_READ;
							STEP_READ: begin
								o_byte_we  <= 1'b1;
								o_byte_idx <= rd_cnt;
								rd_cnt     <= rd_cnt + 4'd1;
								if (rd_cnt == last_idx) begin
									step <= STEP_STOP;
								end
							end
							default: ;
						endcase
					end
				end
				S_WAIT: begin
					if (!i_bus_ack) begin
						o_bus_req <= 1'b1;
						state     <= S_ISSUE;
					end
				end
				S_END: begin
					if (!i_bus_ack) begin
						if (hw_txn) begin
							o_done_hw <= 1'b1;
							state     <= S_IDLE;
						end else begin
							state <= S_ACK;
						end
					end
				end
				S_ACK: begin
					if (!i_req) begin
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_comb begin
		o_bus_cmd = '{op: OP_WRITE, data: 8'h00, last: 1'b0};
		case (step)
			STEP_START, STEP_RSTART: o_bus_cmd.op = OP_START;
			STEP_ADDR_W: o_bus_cmd.data = {cmd.dev_addr, 1'b0};
			STEP_REG:    o_bus_cmd.data = cmd.reg_addr;
			STEP_WDATA:  o_bus_cmd.data = cmd.wdata;
			STEP_ADDR_R: o_bus_cmd.data = {cmd.dev_addr, 1'b1};
			STEP_READ: begin
				o_bus_cmd.op   = OP_READ;
				o_bus_cmd.last = (rd_cnt == last_idx);
			end
			STEP_STOP: o_bus_cmd.op = OP_STOP;
		endcase
	end

	assign o_ack = (state == S_ACK);

endmodule

`default_nettype wire

// ==== logic/rd_data_buf.sv ====
`timescale 1ns/1ps
`default_nettype none

module rd_data_buf (
	input  logic              i_clk,
	input  logic              i_rst_n,
	input  logic              i_byte_we,
	input  logic [3:0]        i_byte_idx,
	input  logic [7:0]        i_byte,
	input  logic              i_done_hw,
	output i2c_pkg::sample_u  o_sample,
	output logic              o_sample_valid
);

	import i2c_pkg::*;

	sample_u samp; // last burst, shared by cpu and poll
	logic    in_range;

	assign in_range = (i_byte_idx < 4'(BURST_BYTES));

	always_ff @(posedge i_clk) begin
		if (i_byte_we && in_range) begin
			samp.bytes[i_byte_idx] <= i_byte;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_sample_valid <= 1'b0;
		end else begin
			o_sample_valid <= i_done_hw; // one cycle after poll ends
		end
	end

	assign o_sample = samp;

endmodule

`default_nettype wire

// ==== logic/i2c_sensor_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_sensor_top #(
	parameter int unsigned QTR_DIV     = 16,
	parameter logic [6:0]  SENSOR_ADDR = 7'h1D
) (
	input  logic               i_clk,
	input  logic               i_rst_n,
	input  logic               i_req,
	input  i2c_pkg::i2c_cmd_t  i_cmd,
	input  logic               i_hw_mode,
	input  logic               i_drdy,
	input  logic               i_sda,
	output logic               o_ack,
	output i2c_pkg::i2c_rsp_t  o_rsp,
	output i2c_pkg::sample_u   o_sample,
	output logic               o_sample_valid,
	output logic               o_scl_oe,
	output logic               o_sda_oe
);

	import i2c_pkg::*;

	logic       bus_req;
	bus_cmd_t   bus_cmd;
	logic       bus_ack;
	bus_rsp_t   bus_rsp;
	logic       tick;
	logic       tick_en;
	logic       byte_we;
	logic [3:0] byte_idx;
	logic       done_hw;
	logic       nack;

	i2c_seq_ctrl #(
		.SENSOR_ADDR(SENSOR_ADDR)
	) u_seq (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_req      (i_req),
		.i_cmd      (i_cmd),
		.i_hw_mode  (i_hw_mode),
		.i_drdy     (i_drdy),
		.i_bus_ack  (bus_ack),
		.i_bus_rsp  (bus_rsp),
		.o_ack      (o_ack),
		.o_nack     (nack),
		.o_bus_req  (bus_req),
		.o_bus_cmd  (bus_cmd),
		.o_byte_we  (byte_we),
		.o_byte_idx (byte_idx),
		.o_done_hw  (done_hw)
	);

	i2c_tick_gen #(
		.QTR_DIV(QTR_DIV)
	) u_tick (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_en    (tick_en),
		.o_tick  (tick)
	);

	i2c_bit_engine u_bit (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_req     (bus_req),
		.i_cmd     (bus_cmd),
		.i_tick    (tick),
		.i_sda     (i_sda),
		.o_ack     (bus_ack),
		.o_rsp     (bus_rsp),
		.o_tick_en (tick_en),
		.o_scl_oe  (o_scl_oe),
		.o_sda_oe  (o_sda_oe)
	);

	rd_data_buf u_buf (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_byte_we      (byte_we),
		.i_byte_idx     (byte_idx),
		.i_byte         (bus_rsp.data), // held until the next bus op
		.i_done_hw      (done_hw),
		.o_sample       (o_sample),
		.o_sample_valid (o_sample_valid)
	);

	assign o_rsp = '{nack: nack, data: o_sample};

endmodule

`default_nettype wire

// ==== tb/adxl_slave_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module adxl_slave_model #(
	parameter logic [6:0] DEV_ADDR = 7'h1D
) (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_scl,
	input  logic i_sda,
	output logic o_sda_oe
);

	typedef enum logic [2:0] {
		P_IDLE,
		P_ADDR,
		P_REG,
		P_WR,
		P_RD
	} phase_e;

	logic [7:0] mem [0:255]; // register file loaded by the testbench
	phase_e     phase;
	phase_e     nxt;
	logic [7:0] ptr;
	logic [7:0] shreg;
	logic [7:0] tx;
	logic [3:0] bit_cnt;
	logic       in_ack;
	logic       mnack;
	logic       scl_q;
	logic       sda_q;
	logic       rise;
	logic       fall;
	logic       start_c;
	logic       stop_c;

	assign rise    = i_scl & ~scl_q;
	assign fall    = ~i_scl & scl_q;
	assign start_c = i_scl & scl_q & sda_q & ~i_sda;
	assign stop_c  = i_scl & scl_q & ~sda_q & i_sda;

	always @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			phase    <= P_IDLE;
			nxt      <= P_IDLE;
			ptr      <= 8'h00;
			bit_cnt  <= 4'd0;
			in_ack   <= 1'b0;
			mnack    <= 1'b0;
			scl_q    <= 1'b1;
			sda_q    <= 1'b1;
			o_sda_oe <= 1'b0;
		end else begin
			scl_q <= i_scl;
			sda_q <= i_sda;
			if (start_c) begin
				phase    <= P_ADDR;
				bit_cnt  <= 4'd0;
				in_ack   <= 1'b0;
				o_sda_oe <= 1'b0;
			end else if (stop_c) begin
				phase    <= P_IDLE;
				o_sda_oe <= 1'b0;
			end else if (phase != P_IDLE) begin
				if (rise) begin
					if (!in_ack) begin
						shreg   <= {shreg[6:0], i_sda};
						bit_cnt <= bit_cnt + 4'd1;
					end else begin
						mnack <= i_sda; // master ack after a sent byte
					end
				end else if (fall) begin
					if (!in_ack && bit_cnt == 4'd8) begin
						in_ack <= 1'b1;
						case (phase)
							P_ADDR: begin
								if (shreg[7:1] == DEV_ADDR) begin
									o_sda_oe <= 1'b1;
									nxt      <= shreg[0] ? P_RD : P_REG;
								end else begin
									o_sda_oe <= 1'b0; // not ours
									nxt      <= P_IDLE;
								end
							end
							P_REG: begin
								ptr      <= shreg;
								o_sda_oe <= 1'b1;
								nxt      <= P_WR;
							end
							P_WR: begin
								mem[ptr] <= shreg;
								ptr      <= ptr + 8'd1;
								o_sda_oe <= 1'b1;
								nxt      <= P_WR;
							end
							default: begin
								o_sda_oe <= 1'b0; // let master ack
								nxt      <= P_RD;
							end
						endcase
					end else if (in_ack) begin
						in_ack  <= 1'b0;
						bit_cnt <= 4'd0;
						if (phase == P_RD && mnack) begin
							phase    <= P_IDLE;
							o_sda_oe <= 1'b0;
						end else if (nxt == P_RD) begin
							phase    <= P_RD;
							tx       <= mem[ptr];
							o_sda_oe <= ~mem[ptr][7];
							ptr      <= ptr + 8'd1; // auto-increment
						end else begin
							phase    <= nxt;
							o_sda_oe <= 1'b0;
						end
					end else if (phase == P_RD) begin
						o_sda_oe <= ~tx[6];
						tx       <= {tx[6:0], 1'b0};
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb/tb_i2c_sensor.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_sensor;

	import i2c_pkg::*;

	localparam int TIMEOUT_CYC = 6000;

	logic       i_clk;
	logic       i_rst_n;
	logic       i_req;
	i2c_cmd_t   i_cmd;
	logic       i_hw_mode;
	logic       i_drdy;
	logic       ack;
	i2c_rsp_t   rsp;
	sample_u    sample;
	logic       sample_valid;
	logic       scl_oe;
	logic       sda_oe;
	logic       slv_sda_oe;
	logic       scl;
	logic       sda;
	logic [7:0] ref_mem [0:255];
	logic [7:0] wbyte;
	logic [87:0] exp_burst;
	logic [31:0] rnd;
	integer     seed;
	int         val_err;
	int         proto_err;
	int         tmo_err;
	int         valid_cnt;
	int         ack_rises;
	int         valid_base;
	int         ack_base;
	int         n;
	logic       ack_q;
	logic       timed_out;

	assign scl = ~scl_oe; // open-drain wired-AND
	assign sda = ~(sda_oe | slv_sda_oe);

	i2c_sensor_top #(
		.QTR_DIV(4),
		.SENSOR_ADDR(7'h1D)
	) uut (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_req          (i_req),
		.i_cmd          (i_cmd),
		.i_hw_mode      (i_hw_mode),
		.i_drdy         (i_drdy),
		.i_sda          (sda),
		.o_ack          (ack),
		.o_rsp          (rsp),
		.o_sample       (sample),
		.o_sample_valid (sample_valid),
		.o_scl_oe       (scl_oe),
		.o_sda_oe       (sda_oe)
	);

	adxl_slave_model #(
		.DEV_ADDR(7'h1D)
	) slave (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.i_scl    (scl),
		.i_sda    (sda),
		.o_sda_oe (slv_sda_oe)
	);

	initial begin
		i_clk = 1'b0;
		forever #4 i_clk = ~i_clk;
	end

	always @(negedge i_clk) begin
		if (sample_valid) valid_cnt++;
		if (ack && !ack_q) ack_rises++;
		ack_q = ack;
	end

	ack_needs_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$rose(ack) |-> $past(i_req))
		else begin
			proto_err++;
			$display("%0t: o_ack rose while i_req was low", $time);
		end

	ack_falls_after_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$fell(ack) |-> !$past(i_req))
		else begin
			proto_err++;
			$display("%0t: o_ack fell while i_req was still high", $time);
		end

	sda_stable_scl_high: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(scl && $past(scl) && (sda != $past(sda)))
		|-> (uut.u_bit.op == OP_START || uut.u_bit.op == OP_STOP))
		else begin
			proto_err++;
			$display("%0t: SDA changed during SCL high outside START or STOP", $time);
		end

	function automatic logic [87:0] expected_burst(input int first);
		logic [87:0] acc;
		acc = '0;
		for (int i = 0; i < BURST_BYTES; i++) begin
			acc = {acc[79:0], ref_mem[first + i]};
		end
		return acc;
	endfunction

	task automatic check_value(input string name, input logic [87:0] exp,
		input logic [87:0] got);
		assert (got === exp) else begin
			val_err++;
			$display("Mismatch at %0t: %s expected %0h actual %0h", $time, name, exp, got);
		end
	endtask

	task automatic check_bus_idle();
		assert (scl === 1'b1 && sda === 1'b1) else begin
			proto_err++;
			$display("%0t: bus lines not both high at end of transaction", $time);
		end
	endtask

	task automatic report_timeout(input string what);
		tmo_err++;
		timed_out = 1'b1;
		$display("%0t: timeout, %s", $time, what);
	endtask

	task automatic cpu_txn(input logic rd, input burst_len_e burst, input logic [6:0] dev,
		input logic [7:0] ra, input logic [7:0] wd);
		int cnt;
		cnt = 0;
		@(posedge i_clk);
		#1;
		i_cmd = '{rd: rd, burst: burst, dev_addr: dev, reg_addr: ra, wdata: wd};
		i_req = 1'b1;
		while (!ack && cnt < TIMEOUT_CYC) begin
			@(posedge i_clk);
			#1;
			cnt++;
		end
		if (!ack) begin
			report_timeout("o_ack never rose for the CPU transaction");
		end else begin
			check_bus_idle();
			i_req = 1'b0;
			cnt = 0;
			while (ack && cnt < 16) begin
				@(posedge i_clk);
				#1;
				cnt++;
			end
			if (ack) report_timeout("o_ack did not fall after i_req dropped");
		end
	endtask

	initial begin
		val_err = 0;
		proto_err = 0;
		tmo_err = 0;
		valid_cnt = 0;
		ack_rises = 0;
		ack_q = 1'b0;
		timed_out = 1'b0;
		seed = 32'h6782259b;
		for (int i = 0; i < 256; i++) begin
			rnd = $random(seed);
			ref_mem[i] = rnd[7:0];
			slave.mem[i] = rnd[7:0];
		end
		i_rst_n = 1'b0;
		i_req = 1'b0;
		i_cmd = '0;
		i_hw_mode = 1'b0;
		i_drdy = 1'b0;
		repeat (8) @(posedge i_clk);
		#1;
		assert (!ack && !scl_oe && !sda_oe) else begin
			proto_err++;
			$display("%0t: outputs not idle after reset", $time);
		end
		i_rst_n = 1'b1;

		// register write then single read-back
		rnd = $random(seed);
		wbyte = rnd[7:0];
		cpu_txn(1'b0, BURST_1, 7'h1D, 8'h2C, wbyte);
		ref_mem[8'h2C] = wbyte;
		check_value("o_rsp.nack", 88'd0, {87'd0, rsp.nack});
		if (!timed_out) cpu_txn(1'b1, BURST_1, 7'h1D, 8'h2C, 8'h00);
		check_value("o_rsp.data.bytes[0]", {80'd0, ref_mem[8'h2C]},
			{80'd0, rsp.data.bytes[0]});
		check_value("o_rsp.nack", 88'd0, {87'd0, rsp.nack});

		// 11-byte burst from the temperature register
		exp_burst = expected_burst(SENSOR_REG_FIRST);
		if (!timed_out) cpu_txn(1'b1, BURST_11, 7'h1D, SENSOR_REG_FIRST, 8'h00);
		check_value("o_rsp.data", exp_burst, rsp.data);
		check_value("o_rsp.data.f.x", {64'd0, ref_mem[8], ref_mem[9], ref_mem[10]},
			{64'd0, rsp.data.f.x});
		check_value("o_rsp.data.f.y", {64'd0, ref_mem[11], ref_mem[12], ref_mem[13]},
			{64'd0, rsp.data.f.y});
		check_value("o_rsp.data.f.z", {64'd0, ref_mem[14], ref_mem[15], ref_mem[16]},
			{64'd0, rsp.data.f.z});
		check_value("o_rsp.nack", 88'd0, {87'd0, rsp.nack});

		// nobody answers at 0x2a
		if (!timed_out) cpu_txn(1'b1, BURST_1, 7'h2A, 8'h06, 8'h00);
		check_value("o_rsp.nack", 88'd1, {87'd0, rsp.nack});
		check_value("o_scl_oe", 88'd0, {87'd0, scl_oe});
		check_value("o_sda_oe", 88'd0, {87'd0, sda_oe});

		// sensor produces a new sample before data-ready
		for (int i = 6; i < 17; i++) begin
			ref_mem[i] = ~ref_mem[i];
			slave.mem[i] = ref_mem[i];
		end
		exp_burst = expected_burst(SENSOR_REG_FIRST);

		// data-ready poll
		if (!timed_out) begin
			valid_base = valid_cnt;
			ack_base = ack_rises;
			@(posedge i_clk);
			#1;
			i_hw_mode = 1'b1;
			i_drdy = 1'b1;
			repeat (3) @(posedge i_clk);
			#1;
			i_drdy = 1'b0;
			n = 0;
			while (!sample_valid && n < TIMEOUT_CYC) begin
				@(posedge i_clk);
				#1;
				n++;
			end
			if (!sample_valid) begin
				report_timeout("o_sample_valid never rose for the poll");
			end else begin
				check_value("o_sample", exp_burst, sample);
				check_bus_idle();
				repeat (TIMEOUT_CYC) @(posedge i_clk); // long enough for a second poll
				#1;
				check_value("o_sample_valid count", 88'd1, 88'(valid_cnt - valid_base));
				check_value("o_ack rises in poll", 88'd0, 88'(ack_rises - ack_base));
			end
			i_hw_mode = 1'b0;
		end

		$display("errors: %0d mismatch, %0d protocol, %0d timeout", val_err, proto_err,
			tmo_err);
		if (val_err == 0 && proto_err == 0 && tmo_err == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== i2c_sensor.f ====
logic/i2c_pkg.sv
logic/i2c_tick_gen.sv
logic/i2c_bit_engine.sv
logic/i2c_seq_ctrl.sv
logic/rd_data_buf.sv
logic/i2c_sensor_top.sv
tb/adxl_slave_model.sv
tb/tb_i2c_sensor.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_i2c_sensor -f i2c_sensor.f -o sim_tb || exit 1

out="$(./obj_dir/sim_tb)"
echo "$out"
grep -qx "sim passed" <<< "$out" && exit 0 || exit 1
